//--- logic/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int XLEN     = 32;
  localparam int NUM_REGS = 32;

  // RV32I major opcodes accepted by the core
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // Matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MEM_BYTE = 2'd0,
    MEM_HALF = 2'd1,
    MEM_WORD = 2'd2
  } mem_width_e;

  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2
  } wb_src_e;

  typedef enum logic [1:0] {
    A_RS1  = 2'd0,
    A_ZERO = 2'd1,
    A_PC   = 2'd2
  } alu_a_src_e;

endpackage

`default_nettype wire

//--- logic/rv_decoder.sv
`default_nettype none

module rv_decoder import rv_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  output alu_op_e         alu_op_o,
  output alu_a_src_e      alu_a_src_o,
  output logic            alu_b_imm_o,
  output logic            reg_write_o,
  output logic            mem_write_o,
  output mem_width_e      mem_width_o,
  output logic            mem_sign_o,
  output wb_src_e         wb_src_o,
  output logic            is_branch_o,
  output logic            is_jal_o,
  output logic            is_jalr_o,
  output logic            illegal_o,
  output logic [XLEN-1:0] imm_o
);

  logic [2:0]      funct3;
  logic            funct7_b5;
  logic [XLEN-1:0] imm_i_type;
  logic [XLEN-1:0] imm_s_type;
  logic [XLEN-1:0] imm_b_type;
  logic [XLEN-1:0] imm_u_type;
  logic [XLEN-1:0] imm_j_type;

  assign funct3    = instr_i[14:12];
  assign funct7_b5 = instr_i[30];

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  // SUB only exists in the register form, SRA/SRAI in both
  function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt,
                                       input logic allow_sub);
    case (f3)
      3'b000:  return (alt && allow_sub) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    alu_op_o    = ALU_ADD;
    alu_a_src_o = A_RS1;
    alu_b_imm_o = 1'b1;
    reg_write_o = 1'b0;
    mem_write_o = 1'b0;
    mem_width_o = MEM_WORD;
    mem_sign_o  = ~funct3[2];
    wb_src_o    = WB_ALU;
    is_branch_o = 1'b0;
    is_jal_o    = 1'b0;
    is_jalr_o   = 1'b0;
    illegal_o   = 1'b0;
    imm_o       = imm_i_type;

    case (funct3[1:0])
      2'b00:   mem_width_o = MEM_BYTE;
      2'b01:   mem_width_o = MEM_HALF;
      default: mem_width_o = MEM_WORD;
    endcase

    case (instr_i[6:0])
      OPC_OP: begin
        alu_op_o    = arith_op(funct3, funct7_b5, 1'b1);
        alu_b_imm_o = 1'b0;
        reg_write_o = 1'b1;
      end
      OPC_OP_IMM: begin
        alu_op_o    = arith_op(funct3, funct7_b5, 1'b0);
        reg_write_o = 1'b1;
      end
      OPC_LOAD: begin
        reg_write_o = 1'b1;
        wb_src_o    = WB_MEM;
      end
      OPC_STORE: begin
        mem_write_o = 1'b1;
        imm_o       = imm_s_type;
      end
      OPC_BRANCH: begin
        is_branch_o = 1'b1;
        imm_o       = imm_b_type;
      end
      OPC_JAL: begin
        is_jal_o    = 1'b1;
        reg_write_o = 1'b1;
        wb_src_o    = WB_PC4;
        imm_o       = imm_j_type;
      end
      OPC_JALR: begin // Target comes out of the ALU
        is_jalr_o   = 1'b1;
        reg_write_o = 1'b1;
        wb_src_o    = WB_PC4;
      end
      OPC_LUI: begin
        alu_op_o    = ALU_PASS_B;
        alu_a_src_o = A_ZERO;
        reg_write_o = 1'b1;
        imm_o       = imm_u_type;
      end
      OPC_AUIPC: begin
        alu_a_src_o = A_PC;
        reg_write_o = 1'b1;
        imm_o       = imm_u_type;
      end
      default: illegal_o = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/rv_regfile.sv
`default_nettype none

module rv_regfile import rv_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic [4:0]      rs1_addr_i,
  input  logic [4:0]      rs2_addr_i,
  input  logic [4:0]      rd_addr_i,
  input  logic [XLEN-1:0] rd_data_i,
  input  logic            rd_we_i,
  output logic [XLEN-1:0] rs1_data_o,
  output logic [XLEN-1:0] rs2_data_o
);

  logic [XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we_i && rd_addr_i != 5'd0) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  // x0 reads as zero regardless of storage
  assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

  // No writeback from the core ever lands in x0
  a_x0_zero: assert property (@(posedge clk_i) disable iff (rst_i)
    regs[0] == '0)
    else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

//--- logic/rv_alu.sv
`default_nettype none

module rv_alu import rv_pkg::*; (
  input  logic [XLEN-1:0] a_i,
  input  logic [XLEN-1:0] b_i,
  input  alu_op_e         op_i,
  output logic [XLEN-1:0] result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:    result_o = a_i + b_i;
      ALU_SUB:    result_o = a_i - b_i;
      ALU_SLL:    result_o = a_i << shamt;
      ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU:   result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR:    result_o = a_i ^ b_i;
      ALU_SRL:    result_o = a_i >> shamt;
      ALU_SRA:    result_o = $unsigned($signed(a_i) >>> shamt); // Keeps sign bit
      ALU_OR:     result_o = a_i | b_i;
      ALU_AND:    result_o = a_i & b_i;
      ALU_PASS_B: result_o = b_i;
      default:    result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/rv_branch.sv
`default_nettype none

module rv_branch import rv_pkg::*; (
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [2:0]      funct3_i,
  output logic [XLEN-1:0] target_o,
  output logic            taken_o
);

  logic equal;
  logic lt_signed;
  logic lt_unsigned;

  assign equal       = rs1_i == rs2_i;
  assign lt_signed   = $signed(rs1_i) < $signed(rs2_i);
  assign lt_unsigned = rs1_i < rs2_i;

  // Shared by branches and JAL
  assign target_o = pc_i + imm_i;

  always_comb begin
    case (funct3_i)
      3'b000:  taken_o = equal;        // beq
      3'b001:  taken_o = ~equal;       // bne
      3'b100:  taken_o = lt_signed;
      3'b101:  taken_o = ~lt_signed;
      3'b110:  taken_o = lt_unsigned;
      3'b111:  taken_o = ~lt_unsigned;
      default: taken_o = 1'b0;         // Reserved encodings fall through
    endcase
  end

endmodule

`default_nettype wire

//--- logic/rv_data_mem.sv
`default_nettype none

module rv_data_mem import rv_pkg::*; #(
  parameter int DMEM_WORDS = 256
) (
  input  logic            clk_i,
  input  logic [XLEN-1:0] addr_i,
  input  logic [XLEN-1:0] wdata_i,
  input  mem_width_e      width_i,
  input  logic            we_i,
  input  logic            sign_i,
  output logic [XLEN-1:0] rdata_o
);

  localparam int IDX_W = $clog2(DMEM_WORDS);

  logic [XLEN-1:0]  mem [DMEM_WORDS];
  logic [IDX_W-1:0] word_idx;
  logic [3:0]       byte_en;
  logic [XLEN-1:0]  wdata_lanes;
  logic [XLEN-1:0]  word;
  logic [XLEN-1:0]  shifted;

  assign word_idx = addr_i[IDX_W+1:2];

  // Replicate store data so any lane picks up the right bits
  always_comb begin
    case (width_i)
      MEM_BYTE: begin
        byte_en     = 4'b0001 << addr_i[1:0];
        wdata_lanes = {4{wdata_i[7:0]}};
      end
      MEM_HALF: begin
        byte_en     = 4'b0011 << {addr_i[1], 1'b0};
        wdata_lanes = {2{wdata_i[15:0]}};
      end
      default: begin
        byte_en     = 4'b1111;
        wdata_lanes = wdata_i;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (byte_en[b]) mem[word_idx][b*8 +: 8] <= wdata_lanes[b*8 +: 8];
      end
    end
  end

  assign word    = mem[word_idx];
  assign shifted = word >> {addr_i[1:0], 3'b000};

  always_comb begin
    case (width_i)
      MEM_BYTE: rdata_o = {{24{sign_i & shifted[7]}}, shifted[7:0]};
      MEM_HALF: rdata_o = {{16{sign_i & shifted[15]}}, shifted[15:0]};
      default:  rdata_o = word;
    endcase
  end

  // Stores issued by the program must be naturally aligned
  a_store_aligned: assert property (@(posedge clk_i)
    we_i |-> (width_i == MEM_BYTE) ||
             (width_i == MEM_HALF && !addr_i[0]) ||
             (addr_i[1:0] == 2'b00))
    else $error("misaligned store to %h", addr_i);

endmodule

`default_nettype wire

//--- logic/rv_core.sv
`default_nettype none

module rv_core import rv_pkg::*; #(
  parameter int              DMEM_WORDS = 256,
  parameter logic [XLEN-1:0] RESET_PC   = '0
) (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            start_i,
  output logic [XLEN-1:0] imem_addr_o,
  input  logic [XLEN-1:0] imem_data_i,
  output logic            retire_o,
  output logic            rd_we_o,
  output logic [4:0]      rd_addr_o,
  output logic [XLEN-1:0] rd_data_o,
  output logic            illegal_o
);

  logic            running;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] next_pc;

  alu_op_e         alu_op;
  alu_a_src_e      alu_a_src;
  logic            alu_b_imm;
  logic            reg_write;
  logic            mem_write;
  mem_width_e      mem_width;
  logic            mem_sign;
  wb_src_e         wb_src;
  logic            is_branch;
  logic            is_jal;
  logic            is_jalr;
  logic            dec_illegal;
  logic [XLEN-1:0] imm;

  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] branch_target;
  logic            taken;
  logic [XLEN-1:0] load_data;
  logic [XLEN-1:0] wb_data;

  // Latches the start pulse until reset
  always_ff @(posedge clk_i) begin
    if (rst_i) running <= 1'b0;
    else if (start_i) running <= 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) pc <= RESET_PC;
    else if (running) pc <= next_pc;
  end

  assign imem_addr_o = pc;
  assign pc_plus4    = pc + 32'd4;

  rv_decoder u_decoder (
    .instr_i     (imem_data_i),
    .alu_op_o    (alu_op),
    .alu_a_src_o (alu_a_src),
    .alu_b_imm_o (alu_b_imm),
    .reg_write_o (reg_write),
    .mem_write_o (mem_write),
    .mem_width_o (mem_width),
    .mem_sign_o  (mem_sign),
    .wb_src_o    (wb_src),
    .is_branch_o (is_branch),
    .is_jal_o    (is_jal),
    .is_jalr_o   (is_jalr),
    .illegal_o   (dec_illegal),
    .imm_o       (imm)
  );

  rv_regfile u_regfile (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rs1_addr_i (imem_data_i[19:15]),
    .rs2_addr_i (imem_data_i[24:20]),
    .rd_addr_i  (imem_data_i[11:7]),
    .rd_data_i  (wb_data),
    .rd_we_i    (rd_we_o),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  always_comb begin
    case (alu_a_src)
      A_ZERO:  alu_a = '0;
      A_PC:    alu_a = pc;
      default: alu_a = rs1_data;
    endcase
  end

  assign alu_b = alu_b_imm ? imm : rs2_data;

  rv_alu u_alu (
    .a_i      (alu_a),
    .b_i      (alu_b),
    .op_i     (alu_op),
    .result_o (alu_result)
  );

  rv_branch u_branch (
    .rs1_i    (rs1_data),
    .rs2_i    (rs2_data),
    .pc_i     (pc),
    .imm_i    (imm),
    .funct3_i (imem_data_i[14:12]),
    .target_o (branch_target),
    .taken_o  (taken)
  );

  always_comb begin
    if (is_jalr) next_pc = {alu_result[XLEN-1:1], 1'b0};
    else if (is_jal || (is_branch && taken)) next_pc = branch_target;
    else next_pc = pc_plus4;
  end

  rv_data_mem #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_data_mem (
    .clk_i   (clk_i),
    .addr_i  (alu_result),
    .wdata_i (rs2_data),
    .width_i (mem_width),
    .we_i    (running & mem_write),
    .sign_i  (mem_sign),
    .rdata_o (load_data)
  );

  always_comb begin
    case (wb_src)
      WB_MEM:  wb_data = load_data;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  assign retire_o  = running;
  assign rd_we_o   = running & reg_write;
  assign rd_addr_o = imem_data_i[11:7];
  assign rd_data_o = wb_data;
  assign illegal_o = running & dec_illegal;

  // Idle core holds its fetch address and commits nothing
  a_idle_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
    !running |-> !retire_o && !rd_we_o && !illegal_o && pc == RESET_PC)
    else $error("core active before start");

endmodule

`default_nettype wire

//--- tests/tb_rv_core.sv
`default_nettype none

module tb_rv_core import rv_pkg::*; ();

  localparam int              CLK_PERIOD   = 10;
  localparam int              RESET_CYCLES = 5;
  localparam int              IDLE_CYCLES  = 3;
  localparam logic [XLEN-1:0] RESET_PC     = 32'h0000_0000;
  localparam logic [XLEN-1:0] NOP_WORD     = 32'h0000_0013; // addi x0, x0, 0
  localparam string           INPUT_FILE   = "tests/rv_core_input.txt";

  logic            clk;
  logic            rst;
  logic            start;
  logic [XLEN-1:0] imem_addr;
  logic [XLEN-1:0] imem_data;
  logic            retire;
  logic            rd_we;
  logic [4:0]      rd_addr;
  logic [XLEN-1:0] rd_data;
  logic            illegal;

  logic [XLEN-1:0] prog_mem [$];
  int              exp_rd [$];
  logic [XLEN-1:0] exp_val [$];
  int              exp_illegal;
  int              illegal_seen;
  int              writes_checked;
  int              errors;
  bit              loaded;
  bit              load_ok;
  bit              start_seen;

  rv_core #(
    .DMEM_WORDS (256),
    .RESET_PC   (RESET_PC)
  ) rv_core_inst (
    .clk_i       (clk),
    .rst_i       (rst),
    .start_i     (start),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .retire_o    (retire),
    .rd_we_o     (rd_we),
    .rd_addr_o   (rd_addr),
    .rd_data_o   (rd_data),
    .illegal_o   (illegal)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // I, E and X records; '#' starts a comment up to the end of the line
  task automatic load_input(output bit ok);
    int              fd;
    int              n;
    int              rd;
    string           tag;
    string           rest;
    logic [XLEN-1:0] word;
    ok = 1'b0;
    fd = $fopen(INPUT_FILE, "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (ok && $fscanf(fd, "%s", tag) == 1) begin
        if (tag == "#") begin
          n = $fgets(rest, fd);
        end else if (tag == "I") begin
          n = $fscanf(fd, "%h", word);
          prog_mem.push_back(word);
          ok = (n == 1);
        end else if (tag == "E") begin
          n = $fscanf(fd, "%d %h", rd, word);
          exp_rd.push_back(rd);
          exp_val.push_back(word);
          ok = (n == 2);
        end else if (tag == "X") begin
          n = $fscanf(fd, "%d", exp_illegal);
          ok = (n == 1);
        end else begin
          $display("Unknown record '%s' in %s", tag, INPUT_FILE);
          ok = 1'b0;
        end
      end
      $fclose(fd);
      if (prog_mem.size() == 0) ok = 1'b0;
    end
  endtask

  function automatic bit in_program(input logic [XLEN-1:0] addr);
    return (addr >> 2) < prog_mem.size();
  endfunction

  task automatic serve_fetch();
    if (in_program(imem_addr)) imem_data = prog_mem[imem_addr >> 2];
    else imem_data = NOP_WORD;
  endtask

  task automatic check_write();
    int              want_rd;
    logic [XLEN-1:0] want_val;
    assert (exp_rd.size() != 0) else begin
      $display("Unexpected write of %h to x%0d at time %0t, none left in the list",
               rd_data, rd_addr, $time);
      errors++;
    end
    if (exp_rd.size() != 0) begin
      want_rd  = exp_rd.pop_front();
      want_val = exp_val.pop_front();
      writes_checked++;
      assert (rd_addr == want_rd && rd_data === want_val) else begin
        $display("CHECK FAILED at %0t: wrote x%0d = %h, expected x%0d = %h",
                 $time, rd_addr, rd_data, want_rd, want_val);
        errors++;
      end
    end
  endtask

  task automatic check_outputs();
    if (!start_seen) begin
      assert (imem_addr === RESET_PC && retire === 1'b0 && rd_we === 1'b0 &&
              illegal === 1'b0) else begin
        $display("CHECK FAILED at %0t: core active before start, addr %h",
                 $time, imem_addr);
        $display("  retire %b, rd_we %b, illegal %b", retire, rd_we, illegal);
        errors++;
      end
    end else begin
      assert (retire === 1'b1) else begin
        $display("CHECK FAILED at %0t: retire low while running", $time);
        errors++;
      end
      // Instruction fetch is always word aligned
      assert (imem_addr[1:0] === 2'b00) else begin
        $display("CHECK FAILED at %0t: fetch address %h is not word aligned",
                 $time, imem_addr);
        errors++;
      end
      if (illegal) begin
        illegal_seen++;
        assert (rd_we === 1'b0) else begin
          $display("CHECK FAILED at %0t: illegal instruction wrote x%0d", $time, rd_addr);
          errors++;
        end
      end
      if (retire && rd_we && rd_addr != 5'd0) check_write();
    end
  endtask

  // Inputs change 1 unit after the edge, outputs are looked at on the falling edge
  task automatic step_cycle(input bit start_pulse);
    @(posedge clk);
    if (start) start_seen = 1'b1;
    #1;
    start = start_pulse;
    serve_fetch();
    @(negedge clk);
    check_outputs();
  endtask

  initial begin
    rst       = 1'b1;
    start     = 1'b0;
    imem_data = NOP_WORD;
    load_input(load_ok);
    if (!load_ok) begin
      $display("Could not read stimulus from %s", INPUT_FILE);
      $display("RESULT: FAIL");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
      serve_fetch();
      @(negedge clk);
      check_outputs();
      repeat (IDLE_CYCLES - 1) step_cycle(1'b0);
      step_cycle(1'b1);
      // Runs until the PC has left the program and every write was seen
      while (exp_rd.size() != 0 || in_program(imem_addr)) step_cycle(1'b0);
      assert (illegal_seen == exp_illegal) else begin
        $display("CHECK FAILED at %0t: %0d illegal instructions, expected %0d",
                 $time, illegal_seen, exp_illegal);
        errors++;
      end
      $display("Writes checked: %0d, illegal seen: %0d, errors: %0d",
               writes_checked, illegal_seen, errors);
      if (errors == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
      $finish;
    end
  end

  initial begin : watchdog
    wait (loaded);
    #((prog_mem.size() + 50) * CLK_PERIOD);
    $display("Timeout: %0d expected writes did not appear", exp_rd.size());
    $display("Writes checked: %0d, illegal seen: %0d, errors: %0d",
             writes_checked, illegal_seen, errors);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
logic/rv_pkg.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/rv_alu.sv
logic/rv_branch.sv
logic/rv_data_mem.sv
logic/rv_core.sv
tests/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - logic/rv_pkg.sv
      - logic/rv_decoder.sv
      - logic/rv_regfile.sv
      - logic/rv_alu.sv
      - logic/rv_branch.sv
      - logic/rv_data_mem.sv
      - logic/rv_core.sv
  - target: test
    files:
      - tests/tb_rv_core.sv

//--- tests/rv_core_input.txt
# I <instruction word, hex>   E <rd, decimal> <value written, hex>
# X <illegal instructions expected, decimal>; E records in commit order
I 00500093 # addi x1, x0, 5
E 1 00000005
I FFD00113 # addi x2, x0, -3
E 2 FFFFFFFD
I 123451B7 # lui x3, 0x12345
E 3 12345000
I 00001217 # auipc x4, 0x1
E 4 0000100C
I 002082B3 # add x5, x1, x2
E 5 00000002
I 40208333 # sub x6, x1, x2
E 6 00000008
I 401153B3 # sra x7, x2, x1
E 7 FFFFFFFF
I 00115433 # srl x8, x2, x1
E 8 07FFFFFF
I 001094B3 # sll x9, x1, x1
E 9 000000A0
I 00112533 # slt x10, x2, x1
E 10 00000001
I 001135B3 # sltu x11, x2, x1
E 11 00000000
I 0020C633 # xor x12, x1, x2
E 12 FFFFFFF8
I 0020E6B3 # or x13, x1, x2
E 13 FFFFFFFD
I 00F17713 # andi x14, x2, 15
E 14 0000000D
I 40115793 # srai x15, x2, 1
E 15 FFFFFFFE
I 08000813 # addi x16, x0, 0x80
E 16 00000080
I 876548B7 # lui x17, 0x87654
E 17 87654000
I 3A988893 # addi x17, x17, 0x3a9
E 17 876543A9
I 01182023 # sw x17, 0(x16)
I 002800A3 # sb x2, 1(x16)
I 00281123 # sh x2, 2(x16)
I 00180903 # lb x18, 1(x16)
E 18 FFFFFFFD
I 00184983 # lbu x19, 1(x16)
E 19 000000FD
I 00281A03 # lh x20, 2(x16)
E 20 FFFFFFFD
I 00285A83 # lhu x21, 2(x16)
E 21 0000FFFD
I 00082B03 # lw x22, 0(x16)
E 22 FFFDFDA9
I 00108463 # beq x1, x1, +8 taken
I 00100C13 # addi x24, x0, 1 skipped
I 00109463 # bne x1, x1, +8 not taken
I 00200C13 # addi x24, x0, 2
E 24 00000002
I 00114463 # blt x2, x1, +8 taken
I 00300C93 # addi x25, x0, 3 skipped
I 00115463 # bge x2, x1, +8 not taken
I 00400C93 # addi x25, x0, 4
E 25 00000004
I 00116463 # bltu x2, x1, +8 not taken
I 00500D13 # addi x26, x0, 5
E 26 00000005
I 00117463 # bgeu x2, x1, +8 taken
I 00600D13 # addi x26, x0, 6 skipped
I 00800DEF # jal x27, +8
E 27 0000009C
I 00700E13 # addi x28, x0, 7 skipped
I 0AD00E93 # addi x29, x0, 0xad
E 29 000000AD
I 000E8F67 # jalr x30, 0(x29) lands on 0xac
E 30 000000A8
I 00900E13 # addi x28, x0, 9 skipped
I 00000F8B # custom-0 opcode with rd x31
I 00000073 # ecall
I FFF00F93 # addi x31, x0, -1
E 31 FFFFFFFF
X 2
